// File: source/display_pkg.sv
/*
 * display package
 * raster size defaults, sync pulse length and the palette
 * index type shared by the scan path
 */

package display_pkg;

    //////////////////////////////////////////////////
    // raster defaults
    //////////////////////////////////////////////////

    // active area in pixels and lines
    localparam int default_h_active = 16;
    localparam int default_v_active = 8;

    // totals include blanking
    localparam int default_h_total = 20;
    localparam int default_v_total = 10;

    // hsync length in pixels, vsync length in lines
    localparam int sync_width = 2;

    //////////////////////////////////////////////////
    // pixel data
    //////////////////////////////////////////////////

    // one entry of the sixteen-color palette
    typedef logic [3:0] pixel_index_t;

endpackage

// File: source/color_pkg.sv
/*
 * color package
 * packed 4/3/3 YUV color word and the sixteen default
 * palette colors loaded on reset
 */

package color_pkg;

    localparam int color_width = 10;

    // y in the top four bits, then cb and cr
    typedef struct packed {
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } yuv_color_t;

    //////////////////////////////////////////////////
    // default colors
    //////////////////////////////////////////////////

    // entry 0, also shown on palette write cycles
    localparam yuv_color_t void_color  = '{4'b0000, 3'b100, 3'b100};
    localparam yuv_color_t grey        = '{4'b1001, 3'b100, 3'b100};
    localparam yuv_color_t white       = '{4'b1111, 3'b011, 3'b011};
    localparam yuv_color_t red         = '{4'b0101, 3'b011, 3'b110};
    localparam yuv_color_t pink        = '{4'b1001, 3'b011, 3'b101};
    localparam yuv_color_t dark_brown  = '{4'b0011, 3'b011, 3'b100};
    localparam yuv_color_t brown       = '{4'b0110, 3'b010, 3'b101};
    localparam yuv_color_t orange      = '{4'b1001, 3'b010, 3'b101};
    localparam yuv_color_t yellow      = '{4'b1101, 3'b010, 3'b100};
    localparam yuv_color_t dark_green  = '{4'b0100, 3'b100, 3'b011};
    localparam yuv_color_t green       = '{4'b0110, 3'b010, 3'b011};
    localparam yuv_color_t light_green = '{4'b1010, 3'b001, 3'b011};
    localparam yuv_color_t night_blue  = '{4'b0010, 3'b100, 3'b011};
    localparam yuv_color_t sea_blue    = '{4'b0100, 3'b101, 3'b010};
    localparam yuv_color_t sky_blue    = '{4'b1000, 3'b101, 3'b010};
    localparam yuv_color_t cloud_blue  = '{4'b1101, 3'b100, 3'b011};

    // indexed by palette entry
    localparam yuv_color_t default_palette [16] = '{
        void_color, grey, white, red,
        pink, dark_brown, brown, orange,
        yellow, dark_green, green, light_green,
        night_blue, sea_blue, sky_blue, cloud_blue
    };

endpackage

// File: source/pixel_stream_if.sv
/*
 * pixel stream
 * one pixel per cycle between pipeline stages, either as a
 * palette index or as a packed color, with its timing bits
 */

`timescale 1ns/1ns

interface pixel_stream_if;

    display_pkg::pixel_index_t index;
    color_pkg::yuv_color_t     color;

    // timing travels with the pixel
    logic active;
    logic hsync;
    logic vsync;

    modport index_source (output index, output active, output hsync, output vsync);
    modport index_sink   (input index, input active, input hsync, input vsync);

    modport color_source (output color, output active, output hsync, output vsync);
    modport color_sink   (input color, input active, input hsync, input vsync);

endinterface

// File: source/raster_timing.sv
/*
 * raster timing generator
 * scans the frame one pixel per cycle and produces registered
 * active, hsync, vsync and the row-major buffer read address
 */

`timescale 1ns/1ns

module raster_timing #(
    parameter int h_active = display_pkg::default_h_active,
    parameter int h_total  = display_pkg::default_h_total,
    parameter int v_active = display_pkg::default_v_active,
    parameter int v_total  = display_pkg::default_v_total
) (
    input  logic clock_in,
    input  logic reset_n_in,
    output logic [$clog2(h_active * v_active)-1:0] read_address,
    output logic active,
    output logic hsync,
    output logic vsync
);

    localparam int h_width       = $clog2(h_total);
    localparam int v_width       = $clog2(v_total);
    localparam int frame_pixels  = h_active * v_active;
    localparam int address_width = $clog2(frame_pixels);

    logic [h_width-1:0]       h_count;
    logic [v_width-1:0]       v_count;
    logic [address_width-1:0] pixel_count;
    logic h_wrap;
    logic v_wrap;
    logic in_active;
    logic in_hsync;
    logic in_vsync;

    assign h_wrap = (int'(h_count) == h_total - 1);
    assign v_wrap = (int'(v_count) == v_total - 1);

    // decode of the current counter position
    assign in_active = (int'(h_count) < h_active) && (int'(v_count) < v_active);
    assign in_hsync  = (int'(h_count) >= h_active) &&
                       (int'(h_count) < h_active + display_pkg::sync_width);
    assign in_vsync  = (int'(v_count) >= v_active) &&
                       (int'(v_count) < v_active + display_pkg::sync_width);

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_wrap) begin
            h_count <= '0;
            v_count <= v_wrap ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // registered outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            read_address <= '0;
            pixel_count  <= '0;
            active       <= 1'b0;
            hsync        <= 1'b0;
            vsync        <= 1'b0;
        end else begin
            active <= in_active;
            hsync  <= in_hsync;
            vsync  <= in_vsync;
            if (in_active) begin
                read_address <= pixel_count;
                // last active pixel restarts the address for the next frame
                if (int'(pixel_count) == frame_pixels - 1) begin
                    pixel_count <= '0;
                end else begin
                    pixel_count <= pixel_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/index_buffer.sv
/*
 * index buffer
 * one palette index per pixel, written by the host and read by
 * the scan in raster order with one cycle of latency
 */

`timescale 1ns/1ns

module index_buffer #(
    parameter int depth = display_pkg::default_h_active * display_pkg::default_v_active
) (
    input  logic clock_in,
    input  logic [$clog2(depth)-1:0] read_address,
    input  logic active,
    input  logic hsync,
    input  logic vsync,
    input  logic write_enable,
    input  logic [$clog2(depth)-1:0] write_address,
    input  display_pkg::pixel_index_t write_index,
    pixel_stream_if.index_source stream
);

    display_pkg::pixel_index_t memory [depth];

    //////////////////////////////////////////////////
    // host write port
    //////////////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_address] <= write_index;
        end
    end

    //////////////////////////////////////////////////
    // scan read port
    //////////////////////////////////////////////////

    // a read colliding with a write sees the old contents
    always_ff @(posedge clock_in) begin
        stream.index <= memory[read_address];
    end

    // timing bits follow the read data by the same cycle
    always_ff @(posedge clock_in) begin
        stream.active <= active;
        stream.hsync  <= hsync;
        stream.vsync  <= vsync;
    end

endmodule

// File: source/color_palette.sv
/*
 * color palette
 * sixteen-entry YUV lookup table, loaded with the default colors
 * on reset and rewritable one entry at a time by the host
 * a write cycle outputs the void color instead of the lookup
 */

`timescale 1ns/1ns

module color_palette (
    input  logic clock_in,
    input  logic reset_n_in,
    pixel_stream_if.index_sink   index_in_stream,
    pixel_stream_if.color_source color_out_stream,
    input  logic write_enable,
    input  display_pkg::pixel_index_t write_entry,
    input  color_pkg::yuv_color_t     write_color
);

    color_pkg::yuv_color_t color_table [16];

    //////////////////////////////////////////////////
    // table and color lookup
    //////////////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            color_table            <= color_pkg::default_palette;
            color_out_stream.color <= color_pkg::void_color;
        end else if (write_enable) begin
            color_table[write_entry] <= write_color;
            // the pixel in flight is dropped to void
            color_out_stream.color   <= color_pkg::void_color;
        end else begin
            color_out_stream.color <= color_table[index_in_stream.index];
        end
    end

    //////////////////////////////////////////////////
    // timing stage
    //////////////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            color_out_stream.active <= 1'b0;
            color_out_stream.hsync  <= 1'b0;
            color_out_stream.vsync  <= 1'b0;
        end else begin
            color_out_stream.active <= index_in_stream.active;
            color_out_stream.hsync  <= index_in_stream.hsync;
            color_out_stream.vsync  <= index_in_stream.vsync;
        end
    end

endmodule

// File: source/yuv_formatter.sv
/*
 * YUV formatter
 * widens the packed 4/3/3 color to 8-bit components by bit
 * repetition and blanks them outside the active area
 */

`timescale 1ns/1ns

module yuv_formatter (
    input  logic clock_in,
    input  logic reset_n_in,
    pixel_stream_if.color_sink stream,
    output logic [7:0] luma,
    output logic [7:0] chroma_b,
    output logic [7:0] chroma_r,
    output logic data_enable,
    output logic hsync,
    output logic vsync
);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            luma        <= '0;
            chroma_b    <= '0;
            chroma_r    <= '0;
            data_enable <= 1'b0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
        end else begin
            data_enable <= stream.active;
            hsync       <= stream.hsync;
            vsync       <= stream.vsync;
            if (stream.active) begin
                luma     <= {stream.color.y, stream.color.y};
                // top two bits refill the low places
                chroma_b <= {stream.color.cb, stream.color.cb, stream.color.cb[2:1]};
                chroma_r <= {stream.color.cr, stream.color.cr, stream.color.cr[2:1]};
            end else begin
                luma     <= '0;
                chroma_b <= '0;
                chroma_r <= '0;
            end
        end
    end

endmodule

// File: source/display_top.sv
/*
 * display top level
 * raster timing, index buffer, palette and formatter chained
 * into a four-stage pixel pipeline with host and panel ports
 */

`timescale 1ns/1ns

module display_top #(
    parameter int h_active = display_pkg::default_h_active,
    parameter int h_total  = display_pkg::default_h_total,
    parameter int v_active = display_pkg::default_v_active,
    parameter int v_total  = display_pkg::default_v_total
) (
    input  logic clock_in,
    input  logic reset_n_in,

    // host side
    input  logic buffer_write_enable,
    input  logic [$clog2(h_active * v_active)-1:0] buffer_write_address,
    input  display_pkg::pixel_index_t buffer_write_index,
    input  logic palette_write_enable,
    input  display_pkg::pixel_index_t palette_write_entry,
    input  logic [color_pkg::color_width-1:0] palette_write_color,

    // panel side
    output logic [7:0] luma,
    output logic [7:0] chroma_b,
    output logic [7:0] chroma_r,
    output logic data_enable,
    output logic hsync,
    output logic vsync
);

    logic [$clog2(h_active * v_active)-1:0] read_address;
    logic raster_active;
    logic raster_hsync;
    logic raster_vsync;

    pixel_stream_if index_stream ();
    pixel_stream_if color_stream ();

    raster_timing #(
        .h_active (h_active),
        .h_total  (h_total),
        .v_active (v_active),
        .v_total  (v_total)
    ) raster_timing_inst (
        .clock_in     (clock_in),
        .reset_n_in   (reset_n_in),
        .read_address (read_address),
        .active       (raster_active),
        .hsync        (raster_hsync),
        .vsync        (raster_vsync)
    );

    index_buffer #(
        .depth (h_active * v_active)
    ) index_buffer_inst (
        .clock_in      (clock_in),
        .read_address  (read_address),
        .active        (raster_active),
        .hsync         (raster_hsync),
        .vsync         (raster_vsync),
        .write_enable  (buffer_write_enable),
        .write_address (buffer_write_address),
        .write_index   (buffer_write_index),
        .stream        (index_stream.index_source)
    );

    color_palette color_palette_inst (
        .clock_in         (clock_in),
        .reset_n_in       (reset_n_in),
        .index_in_stream  (index_stream.index_sink),
        .color_out_stream (color_stream.color_source),
        .write_enable     (palette_write_enable),
        .write_entry      (palette_write_entry),
        .write_color      (color_pkg::yuv_color_t'(palette_write_color))
    );

    yuv_formatter yuv_formatter_inst (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .stream      (color_stream.color_sink),
        .luma        (luma),
        .chroma_b    (chroma_b),
        .chroma_r    (chroma_r),
        .data_enable (data_enable),
        .hsync       (hsync),
        .vsync       (vsync)
    );

endmodule

// File: bench/display_tb.sv
/*
 * display path testbench
 * random buffer fill, palette and buffer rewrites, palette writes
 * in active video and a mid-frame reset, checked pixel by pixel
 * against a model of the palette lookup and color widening
 */

`timescale 1ns/1ns

module display_tb;

    localparam int h_active     = 16;
    localparam int h_total      = 20;
    localparam int v_active     = 8;
    localparam int v_total      = 10;
    localparam int sync_width   = 2;
    localparam int frame_pixels = h_active * v_active;
    localparam int frame_cycles = h_total * v_total;
    // ten frames of tests plus the buffer load, with four frames spare
    localparam int timeout_cycles = 14 * frame_cycles + frame_pixels + 200;

    logic       clock_in = 1'b0;
    logic       reset_n_in;
    logic       buffer_write_enable;
    logic [6:0] buffer_write_address;
    logic [3:0] buffer_write_index;
    logic       palette_write_enable;
    logic [3:0] palette_write_entry;
    logic [9:0] palette_write_color;
    logic [7:0] luma;
    logic [7:0] chroma_b;
    logic [7:0] chroma_r;
    logic       data_enable;
    logic       hsync;
    logic       vsync;

    // reference model
    logic [9:0] model_palette [16];
    logic [3:0] model_buffer [frame_pixels];
    logic [1:0] pending_valid;
    logic [3:0] pending_entry [2];
    logic [9:0] pending_color [2];
    logic [1:0] void_pipe;

    // checker state
    int   pixel_count;
    int   hsync_len;
    int   vsync_lines;
    logic prev_hsync;
    logic prev_vsync;
    logic reset_was_low = 1'b0;
    logic armed = 1'b0;
    logic check_enable = 1'b0;

    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count  = 0;
    int seed         = 19;

    always #2 clock_in = ~clock_in;

    display_top #(
        .h_active (h_active),
        .h_total  (h_total),
        .v_active (v_active),
        .v_total  (v_total)
    ) dut (
        .clock_in             (clock_in),
        .reset_n_in           (reset_n_in),
        .buffer_write_enable  (buffer_write_enable),
        .buffer_write_address (buffer_write_address),
        .buffer_write_index   (buffer_write_index),
        .palette_write_enable (palette_write_enable),
        .palette_write_entry  (palette_write_entry),
        .palette_write_color  (palette_write_color),
        .luma                 (luma),
        .chroma_b             (chroma_b),
        .chroma_r             (chroma_r),
        .data_enable          (data_enable),
        .hsync                (hsync),
        .vsync                (vsync)
    );

    //////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////

    // 3-bit chroma repeated, its top two bits filling the low places
    function automatic logic [7:0] widen_chroma(logic [2:0] value);
        logic [7:0] wide;
        wide = {5'b0, value};
        return (wide << 5) | (wide << 2) | (wide >> 1);
    endfunction

    // packed 4/3/3 color to {y, cb, cr} at 8 bits each
    function automatic logic [23:0] expand_color(logic [9:0] color);
        logic [7:0] y8;
        y8 = 8'(color[9:6]) * 8'd17;
        return {y8, widen_chroma(color[5:3]), widen_chroma(color[2:0])};
    endfunction

    function automatic logic [23:0] expected_pixel(int n);
        return expand_color(model_palette[model_buffer[n]]);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // checker
    //////////////////////////////////////////////////

    always @(posedge clock_in) begin : output_check
        logic [23:0] expected;
        if (!reset_n_in) begin
            // one cycle into reset the outputs are cleared
            if (reset_was_low) begin
                check_value("data_enable", 0, data_enable);
                check_value("hsync", 0, hsync);
                check_value("vsync", 0, vsync);
                check_value("luma", 0, luma);
                check_value("chroma_b", 0, chroma_b);
                check_value("chroma_r", 0, chroma_r);
            end
            reset_was_low = 1'b1;
            for (int i = 0; i < 16; i++) begin
                model_palette[i] = color_pkg::default_palette[i];
            end
            pending_valid = '0;
            void_pipe     = '0;
            pixel_count   = 0;
            hsync_len     = 0;
            vsync_lines   = 0;
            prev_hsync    = 1'b0;
            prev_vsync    = 1'b0;
            armed         = check_enable;
        end else begin
            reset_was_low = 1'b0;
            if (armed) begin
                if (!data_enable) begin
                    expected = '0;
                end else if (void_pipe[1]) begin
                    expected = expand_color(color_pkg::void_color);
                end else begin
                    expected = expected_pixel(pixel_count);
                end
                check_value("luma", expected[23:16], luma);
                check_value("chroma_b", expected[15:8], chroma_b);
                check_value("chroma_r", expected[7:0], chroma_r);
                if (prev_hsync && !hsync) begin
                    check_value("hsync pulse length", sync_width, hsync_len);
                end
                if (prev_vsync && !vsync) begin
                    check_value("vsync pulse lines", sync_width, vsync_lines);
                end
                if (!prev_vsync && vsync) begin
                    check_value("data_enable per frame", frame_pixels, pixel_count);
                end
            end
            if (data_enable) begin
                pixel_count++;
            end
            if (hsync && !prev_hsync && vsync) begin
                vsync_lines++;
            end
            hsync_len = hsync ? hsync_len + 1 : 0;
            // a new frame starts counting from address zero
            if (!prev_vsync && vsync) begin
                pixel_count = 0;
                vsync_lines = 0;
                armed       = check_enable;
            end
            prev_hsync = hsync;
            prev_vsync = vsync;
            // the new entry is seen by the pixel after the void one
            if (pending_valid[1]) begin
                model_palette[pending_entry[1]] = pending_color[1];
            end
            pending_valid    = {pending_valid[0], palette_write_enable};
            pending_entry[1] = pending_entry[0];
            pending_color[1] = pending_color[0];
            pending_entry[0] = palette_write_entry;
            pending_color[0] = palette_write_color;
            void_pipe        = {void_pipe[0], palette_write_enable};
        end
        if (buffer_write_enable) begin
            model_buffer[buffer_write_address] = buffer_write_index;
        end
    end

    always @(posedge clock_in) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus tasks, all entered on a falling edge
    //////////////////////////////////////////////////

    task automatic reset_dut();
        reset_n_in = 1'b0;
        repeat (5) @(negedge clock_in);
        reset_n_in = 1'b1;
    endtask

    task automatic write_buffer(int address, logic [3:0] index);
        buffer_write_enable  = 1'b1;
        buffer_write_address = address[6:0];
        buffer_write_index   = index;
        @(negedge clock_in);
        buffer_write_enable = 1'b0;
    endtask

    task automatic write_palette(logic [3:0] entry, logic [9:0] color);
        palette_write_enable = 1'b1;
        palette_write_entry  = entry;
        palette_write_color  = color;
        @(negedge clock_in);
        palette_write_enable = 1'b0;
    endtask

    // returns once the checker has seen the start of vertical blanking
    task automatic wait_frame_end();
        @(posedge vsync);
        repeat (2) @(negedge clock_in);
    endtask

    task automatic wait_line_start();
        while (data_enable !== 1'b0) @(negedge clock_in);
        while (data_enable !== 1'b1) @(negedge clock_in);
    endtask

    task automatic report_test(int number, string name, int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0d %s: ok", number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin : stimulus
        int         errors_before;
        logic [3:0] entry;
        reset_n_in           = 1'b0;
        buffer_write_enable  = 1'b0;
        buffer_write_address = '0;
        buffer_write_index   = '0;
        palette_write_enable = 1'b0;
        palette_write_entry  = '0;
        palette_write_color  = '0;

        errors_before = error_count;
        reset_dut();
        while (data_enable !== 1'b1) begin
            check_value("hsync", 0, hsync);
            check_value("vsync", 0, vsync);
            @(negedge clock_in);
        end
        for (int a = 0; a < frame_pixels; a++) begin
            write_buffer(a, 4'($random(seed)));
        end
        check_enable = 1'b1;
        wait_frame_end();
        wait_frame_end();
        report_test(1, "reset and default frame", errors_before);

        errors_before = error_count;
        wait_frame_end();
        report_test(2, "frame timing", errors_before);

        errors_before = error_count;
        repeat (4) write_palette(4'($random(seed)), 10'($random(seed)));
        wait_frame_end();
        wait_frame_end();
        report_test(3, "palette rewrite in blanking", errors_before);

        // target the entry of the pixel right after the void one
        errors_before = error_count;
        repeat (3) begin
            wait_line_start();
            repeat (3) @(negedge clock_in);
            entry = model_buffer[(pixel_count + 3) % frame_pixels];
            write_palette(entry, 10'($random(seed)));
        end
        wait_frame_end();
        wait_frame_end();
        report_test(4, "palette write in active video", errors_before);

        errors_before = error_count;
        repeat (6) write_buffer($unsigned($random(seed)) % frame_pixels, 4'($random(seed)));
        wait_frame_end();
        report_test(5, "buffer rewrite in blanking", errors_before);

        errors_before = error_count;
        wait_line_start();
        wait_line_start();
        repeat (5) @(negedge clock_in);
        reset_dut();
        wait_frame_end();
        report_test(6, "mid-frame reset", errors_before);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
source/display_pkg.sv
source/color_pkg.sv
source/pixel_stream_if.sv
source/raster_timing.sv
source/index_buffer.sv
source/color_palette.sv
source/yuv_formatter.sv
source/display_top.sv
bench/display_tb.sv

// File: Bender.yml
package:
  name: display_path

sources:
  - source/display_pkg.sv
  - source/color_pkg.sv
  - source/pixel_stream_if.sv
  - source/raster_timing.sv
  - source/index_buffer.sv
  - source/color_palette.sv
  - source/yuv_formatter.sv
  - source/display_top.sv
  - target: simulation
    files:
      - bench/display_tb.sv
